// File: rtl/ex_pkg.sv
package ex_pkg;

    // datapath width of the core.
    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // instruction class that selects how the op field is read.
    typedef enum logic [1:0] {
        ex_alu     = 2'd0,
        ex_compare = 2'd1,
        ex_branch  = 2'd2,
        ex_jump    = 2'd3
    } execute_type_t;

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_nor   = 4'd5,
        op_sll   = 4'd6,
        op_srl   = 4'd7,
        op_sra   = 4'd8,
        op_pass2 = 4'd9
    } alu_op_t;

    // shares the op field with alu_op_t.
    typedef enum logic [3:0] {
        cmp_eq  = 4'd0,
        cmp_ne  = 4'd1,
        cmp_lt  = 4'd2,
        cmp_ge  = 4'd3,
        cmp_ltu = 4'd4,
        cmp_geu = 4'd5
    } cmp_op_t;

    typedef enum logic [1:0] {sel_rj, sel_pc, sel_zero} src1_sel_t;
    typedef enum logic [1:0] {sel_rk, sel_imm, sel_four} src2_sel_t;

    typedef struct packed {
        execute_type_t ex_type;
        logic [3:0]    op;
        src1_sel_t     src1_sel;
        src2_sel_t     src2_sel;
        logic [2:0]    number_length;
        logic [1:0]    memory_rw;
        logic          writeback_valid;
        logic          writeback_src;
        reg_idx_t      rd_index;
    } ex_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rk_value;
        reg_idx_t        rj_index;
        reg_idx_t        rk_index;
    } ex_data_t;

    typedef struct packed {
        logic [xlen-1:0] value;
        reg_idx_t        rd_index;
        logic            rd_we;
    } fwd_bus_t;

    typedef struct packed {
        logic eq;
        logic lt_s;
        logic lt_u;
    } cmp_flags_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            branch_taken;
        logic [xlen-1:0] branch_target;
        reg_idx_t        rd_index;
        logic [2:0]      number_length;
        logic [1:0]      memory_rw;
        logic            writeback_valid;
        logic            writeback_src;
    } ex_result_t;

endpackage

// File: rtl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
    import ex_pkg::*;
(
    input  reg_idx_t        rj_index,
    input  reg_idx_t        rk_index,
    input  logic [xlen-1:0] rj_reg,
    input  logic [xlen-1:0] rk_reg,
    input  fwd_bus_t        mem1_fwd,
    input  fwd_bus_t        mem2_fwd,
    input  fwd_bus_t        wb_fwd,
    output logic [xlen-1:0] rj_fwd,
    output logic [xlen-1:0] rk_fwd
);

    // mem1 holds the youngest producer and wins over mem2 and writeback.
    function automatic logic [xlen-1:0] pick(
        input reg_idx_t        idx,
        input logic [xlen-1:0] reg_val,
        input fwd_bus_t        m1,
        input fwd_bus_t        m2,
        input fwd_bus_t        wb
    );
        if (idx == '0) begin
            return '0;
        end else if (m1.rd_we && m1.rd_index == idx) begin
            return m1.value;
        end else if (m2.rd_we && m2.rd_index == idx) begin
            return m2.value;
        end else if (wb.rd_we && wb.rd_index == idx) begin
            return wb.value;
        end
        return reg_val;
    endfunction

    always_comb begin
        rj_fwd = pick(rj_index, rj_reg, mem1_fwd, mem2_fwd, wb_fwd);
        rk_fwd = pick(rk_index, rk_reg, mem1_fwd, mem2_fwd, wb_fwd);
    end

    // r0 reads zero even when a later stage claims to write it.
    always_comb begin
        assert #0 (rj_index != '0 || rj_fwd == '0)
            else $error("rj forwarded nonzero for r0");
        assert #0 (rk_index != '0 || rk_fwd == '0)
            else $error("rk forwarded nonzero for r0");
    end

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import ex_pkg::*;
(
    input  alu_op_t         op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] alu_out
);

    logic [4:0] shamt;

    // shifts only look at the low five bits.
    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            op_add: begin
                alu_out = src1 + src2;
            end
            op_sub: begin
                alu_out = src1 - src2;
            end
            op_and: begin
                alu_out = src1 & src2;
            end
            op_or: begin
                alu_out = src1 | src2;
            end
            op_xor: begin
                alu_out = src1 ^ src2;
            end
            op_nor: begin
                alu_out = ~(src1 | src2);
            end
            op_sll: begin
                alu_out = src1 << shamt;
            end
            op_srl: begin
                alu_out = src1 >> shamt;
            end
            op_sra: begin
                alu_out = $unsigned($signed(src1) >>> shamt);
            end
            op_pass2: begin
                // upper immediate arrives already shifted in src2.
                alu_out = src2;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

endmodule

// File: rtl/compare_unit.sv
`timescale 1ns/1ps

module compare_unit
    import ex_pkg::*;
(
    input  logic [xlen-1:0] rj,
    input  logic [xlen-1:0] rk,
    output cmp_flags_t      flags
);

    logic sign_differs;
    logic low_less;

    assign sign_differs = rj[xlen-1] ^ rk[xlen-1];
    assign low_less     = rj[xlen-2:0] < rk[xlen-2:0];

    always_comb begin
        flags.eq   = (rj == rk);
        flags.lt_u = (rj < rk);
        // signs decide first and equal signs fall back to the low bits.
        if (sign_differs) begin
            flags.lt_s = rj[xlen-1];
        end else begin
            flags.lt_s = low_less;
        end
    end

    always_comb begin
        assert #0 (!(flags.eq && flags.lt_u))
            else $error("compare flags eq and lt_u both set");
    end

endmodule

// File: rtl/result_merge.sv
`timescale 1ns/1ps

module result_merge
    import ex_pkg::*;
(
    input  ex_ctrl_t        ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_out,
    input  cmp_flags_t      flags,
    output ex_result_t      res
);

    cmp_op_t cond;
    logic    cond_true;

    assign cond = cmp_op_t'(ctrl.op);

    always_comb begin
        case (cond)
            cmp_eq:  cond_true = flags.eq;
            cmp_ne:  cond_true = !flags.eq;
            cmp_lt:  cond_true = flags.lt_s;
            cmp_ge:  cond_true = !flags.lt_s;
            cmp_ltu: cond_true = flags.lt_u;
            cmp_geu: cond_true = !flags.lt_u;
            default: cond_true = 1'b0;
        endcase
    end

    always_comb begin
        res.result        = alu_out;
        res.branch_taken  = 1'b0;
        res.branch_target = pc + imm;
        case (ctrl.ex_type)
            ex_compare: begin
                // set-less-than only knows the two less-than forms.
                if (cond == cmp_lt) begin
                    res.result = {{(xlen-1){1'b0}}, flags.lt_s};
                end else if (cond == cmp_ltu) begin
                    res.result = {{(xlen-1){1'b0}}, flags.lt_u};
                end else begin
                    res.result = '0;
                end
            end
            ex_branch: begin
                res.branch_taken = cond_true;
            end
            ex_jump: begin
                res.branch_taken  = 1'b1;
                res.branch_target = alu_out;
                res.result        = pc + xlen'(4);
            end
            default: begin
                res.result = alu_out;
            end
        endcase
        res.rd_index        = ctrl.rd_index;
        res.number_length   = ctrl.number_length;
        res.memory_rw       = ctrl.memory_rw;
        res.writeback_valid = ctrl.writeback_valid;
        res.writeback_src   = ctrl.writeback_src;
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       clear,
    input  ex_ctrl_t   ctrl_in,
    input  ex_data_t   data_in,
    input  fwd_bus_t   mem1_fwd,
    input  fwd_bus_t   mem2_fwd,
    input  fwd_bus_t   wb_fwd,
    output ex_result_t ex_out,
    output logic       clear_out
);

    // a bubble writes nothing, touches no memory and never branches.
    localparam ex_ctrl_t bubble_ctrl = '{
        ex_type:         ex_alu,
        op:              4'd0,
        src1_sel:        sel_rj,
        src2_sel:        sel_rk,
        number_length:   3'd0,
        memory_rw:       2'd0,
        writeback_valid: 1'b0,
        writeback_src:   1'b0,
        rd_index:        5'd0
    };

    ex_ctrl_t        ctrl_q;
    ex_data_t        data_q;
    logic [xlen-1:0] rj_fwd;
    logic [xlen-1:0] rk_fwd;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_out;
    alu_op_t         alu_op;
    cmp_flags_t      flags;

    // clear wins over stall.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q    <= bubble_ctrl;
            clear_out <= 1'b0;
        end else begin
            clear_out <= clear;
            if (clear) begin
                ctrl_q <= bubble_ctrl;
            end else if (!stall) begin
                ctrl_q <= ctrl_in;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (clear || !stall) begin
            data_q <= data_in;
        end
    end

    operand_forward u_forward (
        .rj_index (data_q.rj_index),
        .rk_index (data_q.rk_index),
        .rj_reg   (data_q.rj_value),
        .rk_reg   (data_q.rk_value),
        .mem1_fwd (mem1_fwd),
        .mem2_fwd (mem2_fwd),
        .wb_fwd   (wb_fwd),
        .rj_fwd   (rj_fwd),
        .rk_fwd   (rk_fwd)
    );

    always_comb begin
        case (ctrl_q.src1_sel)
            sel_rj:  src1 = rj_fwd;
            sel_pc:  src1 = data_q.pc;
            default: src1 = '0;
        endcase
        case (ctrl_q.src2_sel)
            sel_rk:   src2 = rk_fwd;
            sel_imm:  src2 = data_q.imm;
            sel_four: src2 = xlen'(4);
            default:  src2 = '0;
        endcase
    end

    assign alu_op = alu_op_t'(ctrl_q.op);

    int_alu u_alu (
        .op      (alu_op),
        .src1    (src1),
        .src2    (src2),
        .alu_out (alu_out)
    );

    // the comparator sees the forwarded register operands and ignores the selects.
    compare_unit u_compare (
        .rj    (rj_fwd),
        .rk    (rk_fwd),
        .flags (flags)
    );

    result_merge u_merge (
        .ctrl    (ctrl_q),
        .pc      (data_q.pc),
        .imm     (data_q.imm),
        .alu_out (alu_out),
        .flags   (flags),
        .res     (ex_out)
    );

    clear_out_follows_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear_out |-> $past(clear)
    ) else $error("clear_out without clear");

    stall_holds_ctrl: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && !clear) |=> $stable(ctrl_q)
    ) else $error("stage control changed under stall");

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

endmodule

// File: test/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb
    import ex_pkg::*;
();

    localparam int period_ns      = 20;
    localparam int reset_cycles   = 5;
    localparam int n_idle         = 4;
    localparam int n_alu          = 16 * 9 + 10 * 9;
    localparam int n_cmp          = 2 * (9 + 20);
    localparam int n_branch       = 6 * (9 + 11);
    localparam int n_jump         = 9;
    localparam int n_fwd          = 48;
    localparam int n_hold         = 13;
    localparam int total_vectors  = n_idle + n_alu + n_cmp + n_branch + n_jump + n_fwd + n_hold;
    localparam int timeout_cycles = reset_cycles + total_vectors + 50;

    localparam logic [xlen-1:0] corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       clear;
    ex_ctrl_t   ctrl_in;
    ex_data_t   data_in;
    fwd_bus_t   mem1_fwd;
    fwd_bus_t   mem2_fwd;
    fwd_bus_t   wb_fwd;
    ex_result_t ex_out;
    logic       clear_out;

    ex_ctrl_t   m_ctrl;
    ex_data_t   m_data;
    logic       m_bubble;
    logic       m_clear_out;
    ex_result_t model_out;

    int seed = 74;
    int errors = 0;
    int vec_count = 0;

    tb_clock #(.period_ns(period_ns)) u_clock (.clk(clk));

    execute_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .clear     (clear),
        .ctrl_in   (ctrl_in),
        .data_in   (data_in),
        .mem1_fwd  (mem1_fwd),
        .mem2_fwd  (mem2_fwd),
        .wb_fwd    (wb_fwd),
        .ex_out    (ex_out),
        .clear_out (clear_out)
    );

    function automatic reg_idx_t rand_idx();
        return reg_idx_t'(({$random(seed)} % 31) + 1);
    endfunction

    // small index range so the buses hit the sources often.
    function automatic fwd_bus_t random_bus();
        fwd_bus_t b;
        b.value    = $random(seed);
        b.rd_index = reg_idx_t'({$random(seed)} % 4);
        b.rd_we    = 1'($random(seed));
        return b;
    endfunction

    function automatic logic [xlen-1:0] fwd_value(input reg_idx_t idx, input logic [xlen-1:0] v,
                                                  input fwd_bus_t b1, input fwd_bus_t b2,
                                                  input fwd_bus_t b3);
        if (idx == '0) return '0;
        if (b1.rd_we && b1.rd_index == idx) return b1.value;
        if (b2.rd_we && b2.rd_index == idx) return b2.value;
        if (b3.rd_we && b3.rd_index == idx) return b3.value;
        return v;
    endfunction

    function automatic ex_result_t expected_out(input ex_ctrl_t c, input ex_data_t d,
                                                input fwd_bus_t b1, input fwd_bus_t b2,
                                                input fwd_bus_t b3);
        logic [xlen-1:0] rj;
        logic [xlen-1:0] rk;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] alu;
        logic            lt_s;
        logic            lt_u;
        logic            cond;
        ex_result_t      r;
        rj   = fwd_value(d.rj_index, d.rj_value, b1, b2, b3);
        rk   = fwd_value(d.rk_index, d.rk_value, b1, b2, b3);
        a    = (c.src1_sel == sel_rj) ? rj : (c.src1_sel == sel_pc) ? d.pc : '0;
        b    = (c.src2_sel == sel_rk) ? rk : (c.src2_sel == sel_imm) ? d.imm : xlen'(4);
        lt_s = $signed(rj) < $signed(rk);
        lt_u = rj < rk;
        case (alu_op_t'(c.op))
            op_add:   alu = a + b;
            op_sub:   alu = a - b;
            op_and:   alu = a & b;
            op_or:    alu = a | b;
            op_xor:   alu = a ^ b;
            op_nor:   alu = ~(a | b);
            op_sll:   alu = a << b[4:0];
            op_srl:   alu = a >> b[4:0];
            // logical shift and then refill the vacated top bits with the sign.
            op_sra:   alu = (a >> b[4:0]) | ({xlen{a[xlen-1]}} & ~({xlen{1'b1}} >> b[4:0]));
            op_pass2: alu = b;
            default:  alu = '0;
        endcase
        case (cmp_op_t'(c.op))
            cmp_eq:  cond = (rj == rk);
            cmp_ne:  cond = (rj != rk);
            cmp_lt:  cond = lt_s;
            cmp_ge:  cond = !lt_s;
            cmp_ltu: cond = lt_u;
            cmp_geu: cond = !lt_u;
            default: cond = 1'b0;
        endcase
        r                 = '0;
        r.result          = alu;
        r.branch_target   = d.pc + d.imm;
        if (c.ex_type == ex_compare) begin
            r.result = (c.op == cmp_lt) ? xlen'(lt_s) : (c.op == cmp_ltu) ? xlen'(lt_u) : '0;
        end else if (c.ex_type == ex_branch) begin
            r.branch_taken = cond;
        end else if (c.ex_type == ex_jump) begin
            r.branch_taken  = 1'b1;
            r.branch_target = alu;
            r.result        = d.pc + xlen'(4);
        end
        r.rd_index        = c.rd_index;
        r.number_length   = c.number_length;
        r.memory_rw       = c.memory_rw;
        r.writeback_valid = c.writeback_valid;
        r.writeback_src   = c.writeback_src;
        return r;
    endfunction

    function automatic logic [11:0] passed_fields(input ex_result_t r);
        return {r.rd_index, r.number_length, r.memory_rw, r.writeback_valid, r.writeback_src};
    endfunction

    // reference copy of the stage register where clear beats stall.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_bubble    <= 1'b1;
            m_clear_out <= 1'b0;
        end else begin
            m_clear_out <= clear;
            if (clear) begin
                m_bubble <= 1'b1;
            end else if (!stall) begin
                m_ctrl   <= ctrl_in;
                m_data   <= data_in;
                m_bubble <= 1'b0;
            end
        end
    end

    always_comb begin
        model_out = expected_out(m_ctrl, m_data, mem1_fwd, mem2_fwd, wb_fwd);
    end

    bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        m_bubble |-> (!ex_out.writeback_valid && ex_out.memory_rw == 2'd0
                      && !ex_out.branch_taken))
        else begin
            errors++;
            $display("ERR bubble writeback_valid=%h memory_rw=%h branch_taken=%h",
                     $sampled(ex_out.writeback_valid), $sampled(ex_out.memory_rw),
                     $sampled(ex_out.branch_taken));
        end

    clear_out_match: assert property (@(posedge clk) disable iff (!rst_n)
        clear_out == m_clear_out)
        else begin
            errors++;
            $display("ERR clear_out exp=%h act=%h", $sampled(m_clear_out), $sampled(clear_out));
        end

    result_match: assert property (@(posedge clk) disable iff (!rst_n)
        (!m_bubble && m_ctrl.ex_type != ex_branch) |-> ex_out.result == model_out.result)
        else begin
            errors++;
            $display("ERR result exp=%h act=%h",
                     $sampled(model_out.result), $sampled(ex_out.result));
        end

    taken_match: assert property (@(posedge clk) disable iff (!rst_n)
        !m_bubble |-> ex_out.branch_taken == model_out.branch_taken)
        else begin
            errors++;
            $display("ERR branch_taken exp=%h act=%h",
                     $sampled(model_out.branch_taken), $sampled(ex_out.branch_taken));
        end

    target_match: assert property (@(posedge clk) disable iff (!rst_n)
        (!m_bubble && (m_ctrl.ex_type == ex_branch || m_ctrl.ex_type == ex_jump))
        |-> ex_out.branch_target == model_out.branch_target)
        else begin
            errors++;
            $display("ERR branch_target exp=%h act=%h",
                     $sampled(model_out.branch_target), $sampled(ex_out.branch_target));
        end

    passed_match: assert property (@(posedge clk) disable iff (!rst_n)
        !m_bubble |-> passed_fields(ex_out) == passed_fields(model_out))
        else begin
            errors++;
            $display("ERR passed control fields exp=%h act=%h",
                     passed_fields($sampled(model_out)), passed_fields($sampled(ex_out)));
        end

    task automatic tick();
        @(negedge clk);
        vec_count++;
    endtask

    task automatic send(input execute_type_t t, input logic [3:0] op, input src1_sel_t s1,
                        input src2_sel_t s2, input reg_idx_t ja, input reg_idx_t ka,
                        input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        ex_ctrl_t c;
        ex_data_t d;
        c.ex_type         = t;
        c.op              = op;
        c.src1_sel        = s1;
        c.src2_sel        = s2;
        c.number_length   = 3'($random(seed));
        c.memory_rw       = 2'($random(seed));
        c.writeback_valid = 1'($random(seed));
        c.writeback_src   = 1'($random(seed));
        c.rd_index        = rand_idx();
        d.pc              = 32'($random(seed)) & 32'hffff_fffc;
        d.imm             = $random(seed);
        d.rj_value        = a;
        d.rk_value        = b;
        d.rj_index        = ja;
        d.rk_index        = ka;
        @(negedge clk);
        ctrl_in = c;
        data_in = d;
        vec_count++;
    endtask

    initial begin
        #(timeout_cycles * period_ns);
        $display("timeout, stimulus still running after %0d cycles", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int              op;
        int              s1;
        int              s2;
        int              p;
        int              q;
        int              i;
        int              k;
        cmp_op_t         cop;
        logic [xlen-1:0] r;
        rst_n    = 1'b0;
        stall    = 1'b1;
        clear    = 1'b0;
        data_in  = '0;
        mem1_fwd = '0;
        mem2_fwd = '0;
        wb_fwd   = '0;
        // a waiting jump that must not show up while stalled after reset.
        ctrl_in                 = '0;
        ctrl_in.ex_type         = ex_jump;
        ctrl_in.memory_rw       = 2'd3;
        ctrl_in.writeback_valid = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (n_idle) tick();
        stall = 1'b0;

        for (op = 0; op < 16; op++) begin
            for (s1 = 0; s1 < 3; s1++) begin
                for (s2 = 0; s2 < 3; s2++) begin
                    send(ex_alu, 4'(op), src1_sel_t'(s1), src2_sel_t'(s2), rand_idx(),
                         rand_idx(), $random(seed), $random(seed));
                end
            end
        end
        for (op = 0; op < 10; op++) begin
            for (p = 0; p < 3; p++) begin
                for (q = 0; q < 3; q++) begin
                    send(ex_alu, 4'(op), sel_rj, sel_rk, rand_idx(), rand_idx(),
                         corners[p], corners[q]);
                end
            end
        end

        for (k = 0; k < 2; k++) begin
            cop = (k == 0) ? cmp_lt : cmp_ltu;
            for (p = 0; p < 9; p++) begin
                send(ex_compare, cop, sel_rj, sel_rk, rand_idx(), rand_idx(),
                     corners[p / 3], corners[p % 3]);
            end
            for (i = 0; i < 20; i++) begin
                send(ex_compare, cop, sel_rj, sel_rk, rand_idx(), rand_idx(),
                     $random(seed), $random(seed));
            end
        end

        for (k = 0; k < 6; k++) begin
            cop = cmp_op_t'(k);
            for (p = 0; p < 9; p++) begin
                send(ex_branch, cop, sel_pc, sel_imm, rand_idx(), rand_idx(),
                     corners[p / 3], corners[p % 3]);
            end
            r = $random(seed);
            send(ex_branch, cop, sel_pc, sel_imm, rand_idx(), rand_idx(), r, r);
            for (i = 0; i < 10; i++) begin
                send(ex_branch, cop, sel_pc, sel_imm, rand_idx(), rand_idx(),
                     $random(seed), $random(seed));
            end
        end

        for (k = 0; k < n_jump; k++) begin
            send(ex_jump, op_add, src1_sel_t'(k % 3), src2_sel_t'(k / 3), rand_idx(),
                 rand_idx(), $random(seed), $random(seed));
        end

        // index pairs walk 0..3 against buses that also use 0..3.
        for (i = 0; i < n_fwd; i++) begin
            send(ex_alu, op_sub, sel_rj, sel_rk, reg_idx_t'(i % 4), reg_idx_t'((i / 4) % 4),
                 $random(seed), $random(seed));
            mem1_fwd = random_bus();
            mem2_fwd = random_bus();
            wb_fwd   = random_bus();
        end

        send(ex_alu, op_xor, sel_rj, sel_rk, reg_idx_t'(1), reg_idx_t'(2),
             $random(seed), $random(seed));
        for (i = 0; i < 4; i++) begin
            send(ex_jump, op_add, sel_pc, sel_imm, rand_idx(), rand_idx(),
                 $random(seed), $random(seed));
            stall    = 1'b1;
            mem1_fwd = random_bus();
            mem2_fwd = random_bus();
        end
        send(ex_branch, cmp_ne, sel_pc, sel_imm, rand_idx(), rand_idx(), 32'd1, 32'd2);
        clear = 1'b1;
        send(ex_alu, op_add, sel_rj, sel_imm, rand_idx(), rand_idx(), $random(seed), 32'd0);
        clear = 1'b0;
        stall = 1'b0;
        send(ex_jump, op_add, sel_pc, sel_four, rand_idx(), rand_idx(), 32'd0, 32'd0);
        clear = 1'b1;
        send(ex_alu, op_or, sel_rj, sel_rk, rand_idx(), rand_idx(), $random(seed), 32'd0);
        clear    = 1'b0;
        mem1_fwd = '0;
        mem2_fwd = '0;
        wb_fwd   = '0;
        repeat (4) tick();

        $display("run finished with %0d vectors and %0d errors", vec_count, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/ex_pkg.sv
rtl/operand_forward.sv
rtl/int_alu.sv
rtl/compare_unit.sv
rtl/result_merge.sv
rtl/execute_stage.sv
test/tb_clock.sv
test/execute_stage_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = execute_stage_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
